// ==== src.f ====
source/bicubic_pkg.sv
source/stage_if.sv
source/coord_gen.sv
source/tap_fetch.sv
source/cubic_kernel.sv
source/separable_filter.sv
source/bicubic_scaler.sv
verification/scaler_checker.sv
verification/scaler_monitor.sv
verification/bicubic_tb.sv

// ==== Makefile ====
# Verilator build and run of the bicubic scaler testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module bicubic_tb --Mdir obj_dir -o sim_bicubic
	-./obj_dir/sim_bicubic > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Result: FAIL"; exit 1; \
	elif grep -q "Everything OK" $(LOG); then echo "Result: PASS"; \
	else echo "Result: FAIL, run ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/bicubic_tb.sv ====
/*
 * Bicubic scaler testbench
 * Fills a 100x100 source image from an LFSR, models the source
 * memory and runs one checked frame per parameter set
 */

`timescale 1ns/1ps

module bicubic_tb;
    import bicubic_pkg::*;

    localparam int IMG_SIZE    = 100 * 100;
    localparam int TIMEOUT_CYC = 100000;    // Per frame

    logic        CLK;
    logic        RST;
    coord_t      v0, h0, sw, sh;            // Window origin and size
    dim_t        tw, th;                    // Destination size
    src_addr_t   src_addr;
    pix_t        src_data;
    logic        dst_we;
    logic [11:0] dst_addr;
    pix_t        dst_data;
    logic        done;
    pix_t        src_mem [IMG_SIZE];
    int          src_rd;                    // Address latched at the edge
    int          test_num;
    logic        test_done;
    int          errors;
    int          tests_failed;
    logic        timed_out;

    always #5 CLK = ~CLK;

    // ============================================================
    // Source image and memory model
    // ============================================================
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);     // x^32+x^22+x^2+x+1
    endfunction

    task automatic fill_source_image();
        logic [31:0] lfsr;
        pix_t        pix;
        lfsr = 32'hddb32b71;
        for (int a = 0; a < IMG_SIZE; a++) begin
            for (int b = 0; b < 8; b++) begin
                pix  = {pix[6:0], lfsr[0]};     // One step per bit
                lfsr = lfsr_next(lfsr);
            end
            src_mem[a] = pix;
        end
    endtask

    // Data for the address of the previous cycle
    always @(posedge CLK) begin
        src_rd = int'(src_addr);
        #1;
        src_data = (src_rd < IMG_SIZE) ? src_mem[src_rd] : 8'h00;
    end

    bicubic_scaler #(
        .FRAC_W     (FRAC_W),
        .SRC_STRIDE (100)
    ) i_dut (
        .CLK (CLK), .RST (RST), .V0 (v0), .H0 (h0), .SW (sw), .SH (sh), .TW (tw), .TH (th),
        .src_addr (src_addr), .src_data (src_data),
        .dst_we (dst_we), .dst_addr (dst_addr), .dst_data (dst_data), .DONE (done)
    );

    scaler_monitor i_mon (
        .CLK (CLK), .RST (RST), .v0 (v0), .h0 (h0), .sw (sw), .sh (sh), .tw (tw), .th (th),
        .img (src_mem), .dst_we (dst_we), .dst_addr (dst_addr), .dst_data (dst_data),
        .done (done), .test_num (test_num), .test_done (test_done),
        .errors (errors), .tests_failed (tests_failed)
    );

    bind bicubic_scaler scaler_checker i_chk (
        .CLK (CLK), .RST (RST), .TW (TW), .TH (TH), .dst_we (dst_we),
        .dst_addr (dst_addr), .src_addr (src_addr), .DONE (DONE)
    );

    // New parameters under reset, then one frame
    task automatic run_test(input int num, input coord_t t_v0, input coord_t t_h0,
                            input coord_t t_sw, input coord_t t_sh,
                            input dim_t t_tw, input dim_t t_th, output logic to);
        int cyc;
        @(posedge CLK);
        #1;
        RST      = 1'b1;
        v0       = t_v0;
        h0       = t_h0;
        sw       = t_sw;
        sh       = t_sh;
        tw       = t_tw;
        th       = t_th;
        test_num = num;
        repeat (16) @(posedge CLK);
        #1 RST = 1'b0;
        cyc = 0;
        while (!test_done && cyc < TIMEOUT_CYC) begin
            @(posedge CLK);
            #1;
            cyc++;
        end
        to = !test_done;
        if (to) $display("Test %0d did not finish its frame in %0d cycles", num, cyc);
    endtask

    initial begin
        CLK       = 1'b0;
        RST       = 1'b1;
        v0        = '0;
        h0        = '0;
        sw        = 7'd2;
        sh        = 7'd2;
        tw        = 6'd2;
        th        = 6'd2;
        src_data  = '0;
        test_num  = 0;
        timed_out = 1'b0;
        fill_source_image();
        run_test(1, 7'd3, 7'd5, 7'd8, 7'd8, 6'd8, 6'd8, timed_out);             // Identity
        if (!timed_out) run_test(2, 7'd10, 7'd20, 7'd6, 7'd5, 6'd13, 6'd5, timed_out);
        if (!timed_out) run_test(3, 7'd40, 7'd7, 7'd5, 7'd6, 6'd5, 6'd11, timed_out);
        if (!timed_out) run_test(4, 7'd50, 7'd60, 7'd7, 7'd6, 6'd17, 6'd14, timed_out);
        if (!timed_out) run_test(5, 7'd20, 7'd30, 7'd40, 7'd20, 6'd25, 6'd45, timed_out);
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 test_num, tests_failed, errors, i_dut.i_chk.fail_count);
        if (timed_out || errors != 0 || tests_failed != 0 || i_dut.i_chk.fail_count != 0)
            $display("Something failed");
        else
            $display("Everything OK");
        $finish;
    end

endmodule

// ==== verification/scaler_monitor.sv ====
/*
 * Scaler monitor
 * Reference model of the bicubic mapping and filter; checks every
 * result write, the frame order and the DONE pulse
 */

`timescale 1ns/1ps

module scaler_monitor (
    input  logic                CLK,
    input  logic                RST,
    input  bicubic_pkg::coord_t v0,
    input  bicubic_pkg::coord_t h0,
    input  bicubic_pkg::coord_t sw,
    input  bicubic_pkg::coord_t sh,
    input  bicubic_pkg::dim_t   tw,
    input  bicubic_pkg::dim_t   th,
    input  bicubic_pkg::pix_t   img [10000],   // Source image 100 pixels wide
    input  logic                dst_we,
    input  logic [11:0]         dst_addr,
    input  bicubic_pkg::pix_t   dst_data,
    input  logic                done,
    input  int                  test_num,
    output logic                test_done,      // Frame checked through DONE
    output int                  errors,
    output int                  tests_failed
);
    import bicubic_pkg::*;

    localparam longint ONE = 64'sd1;

    int            err_total  = 0;
    int            fail_total = 0;
    int            frame_errs;
    int            wr_count;
    int            exp_addr;      // Next raster address
    int            frame_size;
    int            exp_data;
    logic          last_wr;       // Final address written last cycle
    logic          after_done;
    logic [4095:0] written;

    // One-dimensional Catmull-Rom rounded half up and clamped
    function automatic int catmull_rom(int pn, int p0, int p1, int p2, longint t);
        longint v;
        v = p0 * (ONE << 46) + t * (ONE << 30) * (p1 - pn)
          + t * t * (ONE << 15) * (2 * pn - 5 * p0 + 4 * p1 - p2)
          + t * t * t * (3 * p0 - 3 * p1 + p2 - pn);
        v = (v + (ONE << 45)) >>> 46;   // Floor of the quotient
        return (v < 0) ? 0 : ((v > 255) ? 255 : int'(v));
    endfunction

    function automatic int src_pix(int r, int c);
        return int'(img[(int'(v0) + r) * 100 + int'(h0) + c]);    // Window relative
    endfunction

    function automatic int row_filter(int r, int c, longint t);
        return catmull_rom(src_pix(r, c - 1), src_pix(r, c), src_pix(r, c + 1),
                           src_pix(r, c + 2), t);
    endfunction

    function automatic int expected_pixel(int x, int y);
        longint px;
        longint py;
        int     bx;
        int     by;
        int     row_res [4];
        px = longint'(x) * (int'(sw) - 1) * 32768 / (int'(tw) - 1);
        py = longint'(y) * (int'(sh) - 1) * 32768 / (int'(th) - 1);
        bx = int'(px / 32768);
        by = int'(py / 32768);
        px = px % 32768;                // Phases from here on
        py = py % 32768;
        if (px == 0 && py == 0) return src_pix(by, bx);
        if (py == 0) return row_filter(by, bx, px);
        if (px == 0)
            return catmull_rom(src_pix(by - 1, bx), src_pix(by, bx), src_pix(by + 1, bx),
                               src_pix(by + 2, bx), py);
        for (int i = 0; i < 4; i++) begin
            row_res[i] = row_filter(by + i - 1, bx, px);   // Byte per row
        end
        return catmull_rom(row_res[0], row_res[1], row_res[2], row_res[3], py);
    endfunction

    function automatic void note_error();
        err_total++;
        frame_errs++;
    endfunction

    // ============================================================
    // Write and DONE checking
    // ============================================================
    always @(posedge CLK) begin
        frame_size = int'(tw) * int'(th);
        if (RST) begin
            exp_addr   = 0;
            wr_count   = 0;
            frame_errs = 0;
            written    = '0;
            last_wr    = 1'b0;
            after_done = 1'b0;
            test_done <= 1'b0;
        end else if (!test_done) begin
            if (done) begin
                if (!last_wr) begin
                    $display("DONE came without the final write in the cycle before it");
                    note_error();
                end
                if (wr_count != frame_size) begin
                    $display("Frame ended after %0d writes, %0d expected",
                             wr_count, frame_size);
                    note_error();
                end
                after_done = 1'b1;
                exp_addr   = 0;             // Next frame starts over
            end else if (last_wr) begin
                $display("DONE missing in the cycle after the final write");
                note_error();
            end
            last_wr = 1'b0;
            if (dst_we) begin
                if (int'(dst_addr) != exp_addr) begin
                    $display("ERR dst_addr: got 0x%03h, expected 0x%03h",
                             dst_addr, exp_addr[11:0]);
                    note_error();
                end
                if (int'(dst_addr) < frame_size) begin
                    exp_data = expected_pixel(int'(dst_addr) % int'(tw),
                                              int'(dst_addr) / int'(tw));
                    if (int'(dst_data) != exp_data) begin
                        $display("ERR dst_data at 0x%03h: got 0x%02h, expected 0x%02h",
                                 dst_addr, dst_data, exp_data[7:0]);
                        note_error();
                    end
                    // Identity scaling copies the window
                    if (sw == coord_t'(tw) && sh == coord_t'(th)) begin
                        exp_data = src_pix(int'(dst_addr) / int'(tw),
                                           int'(dst_addr) % int'(tw));
                        if (int'(dst_data) != exp_data) begin
                            $display("ERR dst_data at 0x%03h: got 0x%02h, source pixel 0x%02h",
                                     dst_addr, dst_data, exp_data[7:0]);
                            note_error();
                        end
                    end
                end
                if (after_done) begin
                    $write("Test %0d: V0=%0d H0=%0d SW=%0d SH=%0d TW=%0d TH=%0d, ",
                           test_num, v0, h0, sw, sh, tw, th);
                    $display("%0d writes, %0d errors, %s", wr_count, frame_errs,
                             (frame_errs == 0) ? "pass" : "FAIL");
                    if (frame_errs != 0) fail_total++;
                    test_done <= 1'b1;
                end else begin
                    if (written[dst_addr]) begin
                        $display("Address 0x%03h written twice in one frame", dst_addr);
                        note_error();
                    end
                    written[dst_addr] = 1'b1;
                    wr_count++;
                    exp_addr++;
                    last_wr = (int'(dst_addr) == frame_size - 1);
                end
            end
        end
        errors       <= err_total;
        tests_failed <= fail_total;
    end

endmodule

// ==== verification/scaler_checker.sv ====
/*
 * Scaler port checker
 * Concurrent assertions on reset behavior, address ranges and
 * the DONE pulse, bound into the scaler top level
 */

`timescale 1ns/1ps

module scaler_checker (
    input logic                   CLK,
    input logic                   RST,
    input bicubic_pkg::dim_t      TW,
    input bicubic_pkg::dim_t      TH,
    input logic                   dst_we,
    input logic [11:0]            dst_addr,
    input bicubic_pkg::src_addr_t src_addr,
    input logic                   DONE
);
    int fail_count = 0;     // Read by the testbench at the end

    quiet_in_reset: assert property (@(posedge CLK) RST |-> (!dst_we && !DONE))
        else begin
            fail_count++;
            $error("Write strobe or DONE high during reset");
        end

    dst_addr_in_frame: assert property (@(posedge CLK) disable iff (RST)
        dst_we |-> (dst_addr < 12'(TW) * 12'(TH)))
        else begin
            fail_count++;
            $error("Write address outside the destination frame");
        end

    src_addr_in_image: assert property (@(posedge CLK) disable iff (RST)
        src_addr < 14'd10000)
        else begin
            fail_count++;
            $error("Source address outside the 100x100 image");
        end

    done_single_cycle: assert property (@(posedge CLK) disable iff (RST) DONE |=> !DONE)
        else begin
            fail_count++;
            $error("DONE high for more than one cycle");
        end

endmodule

// ==== source/bicubic_scaler.sv ====
/*
 * Bicubic image scaler, top level
 * Coordinate generation, tap fetch and filtering joined by two
 * valid and ready links
 */

`timescale 1ns/1ps

module bicubic_scaler #(
    parameter int FRAC_W     = bicubic_pkg::FRAC_W,
    parameter int SRC_STRIDE = bicubic_pkg::SRC_STRIDE_DEF
) (
    input  logic                   CLK,
    input  logic                   RST,
    input  bicubic_pkg::coord_t    V0,         // Window top row
    input  bicubic_pkg::coord_t    H0,         // Window left column
    input  bicubic_pkg::coord_t    SW,         // Window size
    input  bicubic_pkg::coord_t    SH,
    input  bicubic_pkg::dim_t      TW,         // Destination size
    input  bicubic_pkg::dim_t      TH,
    output bicubic_pkg::src_addr_t src_addr,   // Source read, one cycle latency
    input  bicubic_pkg::pix_t      src_data,
    output logic                   dst_we,     // Result write
    output logic [11:0]            dst_addr,
    output bicubic_pkg::pix_t      dst_data,
    output logic                   DONE
);
    import bicubic_pkg::*;

    stage_if #(.T(pixel_job_t)) job_link ();
    stage_if #(.T(tap_set_t))   tap_link ();

    coord_gen #(
        .FRAC_W (FRAC_W)
    ) u_coord_gen (
        .CLK (CLK),
        .RST (RST),
        .sw  (SW),
        .sh  (SH),
        .tw  (TW),
        .th  (TH),
        .job (job_link.src)
    );

    tap_fetch #(
        .SRC_STRIDE (SRC_STRIDE)
    ) u_tap_fetch (
        .CLK      (CLK),
        .RST      (RST),
        .v0       (V0),
        .h0       (H0),
        .job      (job_link.dst),
        .taps     (tap_link.src),
        .src_addr (src_addr),
        .src_data (src_data)
    );

    separable_filter u_filter (
        .CLK      (CLK),
        .RST      (RST),
        .taps     (tap_link.dst),
        .tw       (TW),
        .dst_we   (dst_we),
        .dst_addr (dst_addr),
        .dst_data (dst_data),
        .done     (DONE)
    );

endmodule

// ==== source/separable_filter.sv ====
/*
 * Separable filter
 * Drives the one shared kernel over a row, a column, or four rows
 * and a column, then writes the pixel and flags the end of frame
 */

`timescale 1ns/1ps

module separable_filter (
    input  logic              CLK,
    input  logic              RST,
    stage_if.dst              taps,
    input  bicubic_pkg::dim_t tw,
    output logic              dst_we,
    output logic [11:0]       dst_addr,
    output bicubic_pkg::pix_t dst_data,
    output logic              done
);
    import bicubic_pkg::*;

    tap_set_t          cur;         // Tap set being filtered
    logic              cur_last;
    logic              busy;
    logic [2:0]        step;        // Cycles since the transfer
    logic [2:0]        step_end;    // Write cycle of this mode
    pix_t              row_buf [3]; // Rows -1..+1 in BOTH mode
    pix_t              k_taps [4];
    logic [FRAC_W-1:0] k_frac;
    pix_t              k_result;

    // ============================================================
    // Kernel operand select
    // ============================================================
    always_comb begin
        k_frac = cur.fx;
        for (int i = 0; i < 4; i++) begin
            k_taps[i] = cur.tap[4 + i];         // Base row
        end
        case (cur.mode)
            VERT: begin
                k_frac = cur.fy;
                for (int i = 0; i < 4; i++) begin
                    k_taps[i] = cur.tap[4 * i + 1];     // Base column
                end
            end
            BOTH: begin
                if (step == 3'd4) begin         // Column pass over row results
                    k_frac    = cur.fy;
                    k_taps[0] = row_buf[0];
                    k_taps[1] = row_buf[1];
                    k_taps[2] = row_buf[2];
                    k_taps[3] = k_result;       // Row +2 straight from the kernel
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        k_taps[i] = cur.tap[4 * int'(step[1:0]) + i];
                    end
                end
            end
            default: ;
        endcase
    end

    cubic_kernel #(
        .FRAC_W (FRAC_W)
    ) u_kernel (
        .CLK     (CLK),
        .RST     (RST),
        .taps_in (k_taps),
        .frac    (k_frac),
        .result  (k_result)
    );

    // ============================================================
    // Sequencing and write port
    // ============================================================
    always_comb begin
        case (cur.mode)
            COPY:    step_end = 3'd0;
            BOTH:    step_end = 3'd5;
            default: step_end = 3'd1;   // One kernel pass
        endcase
    end

    assign taps.ready = !busy;
    assign dst_we     = busy && (step == step_end);
    assign dst_addr   = 12'(cur.dy) * 12'(tw) + 12'(cur.dx);
    assign dst_data   = (cur.mode == COPY) ? cur.tap[5] : k_result;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= dst_we && cur_last;     // One cycle after the final write
            if (taps.valid && taps.ready) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 3'd1;
                if (step == step_end) busy <= 1'b0;
            end
        end
    end

    // Payload and row results
    always_ff @(posedge CLK) begin
        if (taps.valid && taps.ready) begin
            cur      <= taps.payload;
            cur_last <= taps.last;
        end
        if (busy && cur.mode == BOTH && step >= 3'd1 && step <= 3'd3) begin
            row_buf[step[1:0] - 2'd1] <= k_result;  // Result of the previous row
        end
    end

endmodule

// ==== source/cubic_kernel.sv ====
/*
 * Catmull-Rom kernel
 * Four taps and a phase give one pixel, rounded half up,
 * clamped to 8 bits and registered
 */

`timescale 1ns/1ps

module cubic_kernel #(
    parameter int FRAC_W = bicubic_pkg::FRAC_W
) (
    input  logic              CLK,
    input  logic              RST,
    input  bicubic_pkg::pix_t taps_in [4],     // pn, p0, p1, p2
    input  logic [FRAC_W-1:0] frac,
    output bicubic_pkg::pix_t result
);
    import bicubic_pkg::*;

    localparam int OUT_SH = 3 * FRAC_W + 1;    // Scale of the p0 term

    logic signed [KERN_ACC_W-1:0] pn, p0, p1, p2;
    logic signed [KERN_ACC_W-1:0] t, t2, t3;
    logic signed [KERN_ACC_W-1:0] acc;
    logic signed [KERN_ACC_W-1:0] rnd;
    pix_t                         clamped;

    always_comb begin
        pn = KERN_ACC_W'(taps_in[0]);   // Zero extended, always positive
        p0 = KERN_ACC_W'(taps_in[1]);
        p1 = KERN_ACC_W'(taps_in[2]);
        p2 = KERN_ACC_W'(taps_in[3]);
        t  = KERN_ACC_W'(frac);
        t2 = t * t;
        t3 = t2 * t;

        acc = (p0 <<< OUT_SH)
            + ((t * (p1 - pn)) <<< (2 * FRAC_W))
            + ((t2 * (2 * pn - 5 * p0 + 4 * p1 - p2)) <<< FRAC_W)
            + t3 * (3 * p0 - 3 * p1 + p2 - pn);

        // Half up, then floor
        rnd = (acc + (KERN_ACC_W'(1) <<< (OUT_SH - 1))) >>> OUT_SH;

        if (rnd < 0)
            clamped = '0;
        else if (rnd > 255)
            clamped = '1;
        else
            clamped = rnd[PIX_W-1:0];
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) result <= '0;
        else     result <= clamped;
    end

endmodule

// ==== source/tap_fetch.sv ====
/*
 * Tap fetch
 * Reads the 1, 4 or 16 source pixels a job needs, one address per
 * cycle, and hands the assembled tap set to the filter
 */

`timescale 1ns/1ps

module tap_fetch #(
    parameter int SRC_STRIDE = bicubic_pkg::SRC_STRIDE_DEF
) (
    input  logic                   CLK,
    input  logic                   RST,
    input  bicubic_pkg::coord_t    v0,
    input  bicubic_pkg::coord_t    h0,
    stage_if.dst                   job,
    stage_if.src                   taps,
    output bicubic_pkg::src_addr_t src_addr,
    input  bicubic_pkg::pix_t      src_data
);
    import bicubic_pkg::*;

    typedef enum logic [1:0] {F_IDLE, F_FETCH, F_HOLD} fstate_t;

    fstate_t     state;
    pixel_job_t  cur;           // Job being fetched
    logic        cur_last;
    logic [3:0]  cnt;           // Read counter
    logic [3:0]  cnt_end;
    logic [1:0]  ri;            // Tap row, 0 is row -1
    logic [1:0]  ci;            // Tap column, 0 is column -1
    logic        cap_en;        // Byte on src_data this cycle
    logic        cap_last;
    logic [3:0]  cap_slot;      // Counter delayed by one cycle
    pix_t [15:0] tap_q;
    coord_t      src_row;
    coord_t      src_col;

    // ============================================================
    // Tap pattern per mode
    // ============================================================
    always_comb begin
        case (cur.mode)
            COPY: begin
                ri = 2'd1;
                ci = 2'd1;
                cnt_end = 4'd0;
            end
            HORIZ: begin
                ri = 2'd1;
                ci = cnt[1:0];      // Columns -1..+2
                cnt_end = 4'd3;
            end
            VERT: begin
                ri = cnt[1:0];      // Rows -1..+2
                ci = 2'd1;
                cnt_end = 4'd3;
            end
            default: begin
                ri = cnt[3:2];
                ci = cnt[1:0];
                cnt_end = 4'd15;
            end
        endcase
    end

    assign src_row  = v0 + cur.row + coord_t'(ri) - 7'd1;
    assign src_col  = h0 + cur.col + coord_t'(ci) - 7'd1;
    assign src_addr = src_addr_t'(src_row) * src_addr_t'(SRC_STRIDE) + src_addr_t'(src_col);

    assign job.ready = (state == F_IDLE);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state      <= F_IDLE;
            cnt        <= '0;
            cap_en     <= 1'b0;
            cap_last   <= 1'b0;
            cap_slot   <= '0;
            taps.valid <= 1'b0;
            cur        <= '0;   // Keeps the idle address inside the image
            cur_last   <= 1'b0;
        end else begin
            cap_en   <= (state == F_FETCH);
            cap_last <= (state == F_FETCH) && (cnt == cnt_end);
            cap_slot <= {ri, ci};
            case (state)
                F_IDLE: if (job.valid) begin
                    cur      <= job.payload;
                    cur_last <= job.last;
                    cnt      <= '0;
                    state    <= F_FETCH;
                end
                F_FETCH: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == cnt_end) state <= F_HOLD;
                end
                default: if (taps.valid && taps.ready) begin
                    taps.valid <= 1'b0;
                    state      <= F_IDLE;
                end
            endcase
            if (cap_last) taps.valid <= 1'b1;   // Last byte lands now
        end
    end

    // Tap storage
    always_ff @(posedge CLK) begin
        if (cap_en) tap_q[cap_slot] <= src_data;
    end

    assign taps.payload = '{tap: tap_q, fx: cur.fx, fy: cur.fy, mode: cur.mode,
                            dx: cur.dx, dy: cur.dy};
    assign taps.last    = cur_last;

endmodule

// ==== source/coord_gen.sv ====
/*
 * Coordinate generator
 * Walks the destination raster, maps each pixel to a fixed point
 * source position and issues one job per pixel
 */

`timescale 1ns/1ps

module coord_gen #(
    parameter int FRAC_W = bicubic_pkg::FRAC_W
) (
    input  logic                CLK,
    input  logic                RST,
    input  bicubic_pkg::coord_t sw,
    input  bicubic_pkg::coord_t sh,
    input  bicubic_pkg::dim_t   tw,
    input  bicubic_pkg::dim_t   th,
    stage_if.src                job
);
    import bicubic_pkg::*;

    localparam int POS_W = COORD_W + FRAC_W;            // Integer and fraction
    localparam int NUM_W = DIM_W + COORD_W + FRAC_W;    // Dividend

    dim_t             x_q;      // Next pixel to issue
    dim_t             y_q;
    logic             primed;   // One idle cycle after reset
    logic             load;
    logic [POS_W-1:0] pos_x;
    logic [POS_W-1:0] pos_y;
    pixel_job_t       job_d;

    // Truncated d * (s-1) * 2^FRAC_W / (t-1)
    function automatic logic [POS_W-1:0] map_pos(dim_t d, coord_t s_m1, dim_t t_m1);
        logic [NUM_W-1:0] num;
        num = NUM_W'(d) * NUM_W'(s_m1);
        num = num << FRAC_W;
        return POS_W'(num / NUM_W'(t_m1));
    endfunction

    assign pos_x = map_pos(x_q, sw - 7'd1, tw - 6'd1);
    assign pos_y = map_pos(y_q, sh - 7'd1, th - 6'd1);

    always_comb begin
        job_d.dx   = x_q;
        job_d.dy   = y_q;
        job_d.col  = pos_x[POS_W-1:FRAC_W];
        job_d.row  = pos_y[POS_W-1:FRAC_W];
        job_d.fx   = pos_x[FRAC_W-1:0];
        job_d.fy   = pos_y[FRAC_W-1:0];
        job_d.mode = mode_t'({|pos_y[FRAC_W-1:0], |pos_x[FRAC_W-1:0]});
    end

    assign load = primed && (!job.valid || job.ready);   // Slot empty or draining

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            primed    <= 1'b0;
            job.valid <= 1'b0;
            x_q       <= '0;
            y_q       <= '0;
        end else begin
            primed <= 1'b1;
            if (load) begin
                job.valid <= 1'b1;
                if (x_q == tw - 6'd1) begin     // End of row
                    x_q <= '0;
                    y_q <= (y_q == th - 6'd1) ? '0 : y_q + 6'd1;
                end else begin
                    x_q <= x_q + 6'd1;
                end
            end
        end
    end

    // Job payload held until it transfers
    always_ff @(posedge CLK) begin
        if (load) begin
            job.payload <= job_d;
            job.last    <= (x_q == tw - 6'd1) && (y_q == th - 6'd1);
        end
    end

endmodule

// ==== source/stage_if.sv ====
/*
 * Stage link
 * Valid and ready pair with a payload of any type and a flag
 * marking the last pixel of the frame
 */

`timescale 1ns/1ps

interface stage_if #(
    parameter type T = logic    // Payload carried by the link
);

    logic valid;    // Source holds item until accepted
    logic ready;    // Destination can take an item
    logic last;     // Item is the final pixel of the frame
    T     payload;

    modport src (output valid, output payload, output last, input ready);
    modport dst (input valid, input payload, input last, output ready);

endinterface

// ==== source/bicubic_pkg.sv ====
/*
 * Bicubic scaler shared definitions
 * Pixel, coordinate and address widths, the filter mode encoding
 * and the payloads passed between the three scaler stages
 */

package bicubic_pkg;

    // ============================================================
    // Widths and constants
    // ============================================================
    localparam int PIX_W          = 8;      // Source and result pixel
    localparam int FRAC_W         = 15;     // Fraction bits of a source position
    localparam int COORD_W        = 7;      // Source row or column
    localparam int DIM_W          = 6;      // Destination x, y and sizes
    localparam int ADDR_W         = 14;     // Source memory address
    localparam int SRC_STRIDE_DEF = 100;    // Source image width
    localparam int KERN_ACC_W     = 64;     // Signed kernel accumulator

    typedef logic [PIX_W-1:0]   pix_t;
    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [DIM_W-1:0]   dim_t;
    typedef logic [ADDR_W-1:0]  src_addr_t;

    // Bit 0 set for a nonzero horizontal fraction, bit 1 for vertical
    typedef enum logic [1:0] {
        COPY  = 2'b00,  // Base pixel as is
        HORIZ = 2'b01,  // Four taps along the base row
        VERT  = 2'b10,  // Four taps along the base column
        BOTH  = 2'b11   // Four row passes then one column pass
    } mode_t;

    // ============================================================
    // Stage payloads
    // ============================================================
    typedef struct packed {
        dim_t              dx;      // Destination column
        dim_t              dy;      // Destination row
        coord_t            row;     // Base row inside the window
        coord_t            col;     // Base column inside the window
        logic [FRAC_W-1:0] fx;      // Horizontal phase
        logic [FRAC_W-1:0] fy;      // Vertical phase
        mode_t             mode;
    } pixel_job_t;

    typedef struct packed {
        pix_t [15:0]       tap;     // Index = 4*row + col, both counted from -1
        logic [FRAC_W-1:0] fx;
        logic [FRAC_W-1:0] fy;
        mode_t             mode;
        dim_t              dx;
        dim_t              dy;
    } tap_set_t;

endpackage
